// File: common/isaPkg.sv
////////////////////
// isa definitions for the integer back end
// word and register widths, alu operations, exception codes
////////////////////
package isaPkg;

    // data and address width
    localparam int wordWidth = 32;
    // register index width
    localparam int gprNum = 5;
    // architectural register count
    localparam int gprCount = 1 << gprNum;
    // immediate field width
    localparam int immWidth = 16;

    // alu function select
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLL  = 3'd5,
        ALU_LUI  = 3'd6,
        // add that traps on signed overflow
        ALU_ADDO = 3'd7
    } aluOp_t;

    // normal op or unconditional trap
    typedef enum logic [0:0] {
        KIND_NORMAL = 1'b0,
        KIND_TRAP   = 1'b1
    } opKind_t;

    // exception cause in mips style numbering
    typedef enum logic [4:0] {
        EXC_NONE     = 5'd0,
        EXC_OVERFLOW = 5'd12,
        EXC_TRAP     = 5'd13
    } excCode_t;

endpackage

// File: common/pipePkg.sv
////////////////////
// pipeline payload types
// issue word, inter-stage payload, forwarding and report structs
////////////////////
package pipePkg;

    import isaPkg::*;

    // one issued operation
    typedef struct packed {
        logic [gprNum-1:0]    dest;
        logic [gprNum-1:0]    srcA;
        logic [gprNum-1:0]    srcB;
        logic                 useImm;
        logic [immWidth-1:0]  imm;
        aluOp_t               aluOp;
        opKind_t              kind;
        logic [wordWidth-1:0] vaddr;
    } issueOp_t;

    // payload between exec, reexe and commit
    // writeNum of 0 means no register write
    typedef struct packed {
        logic [gprNum-1:0]    writeNum;
        logic [wordWidth-1:0] result;
        logic [wordWidth-1:0] vaddr;
        logic                 hasException;
        excCode_t             excCode;
    } stageData_t;

    // forwarding source seen by exec
    typedef struct packed {
        logic                 valid;
        logic [gprNum-1:0]    writeNum;
        logic [wordWidth-1:0] data;
    } fwdPort_t;

    // retired op report
    typedef struct packed {
        logic [gprNum-1:0]    writeNum;
        logic [wordWidth-1:0] data;
        logic [wordWidth-1:0] vaddr;
    } commitInfo_t;

    // exception report
    typedef struct packed {
        excCode_t             excCode;
        logic [wordWidth-1:0] epc;
    } excInfo_t;

    // operand source picked per operand in exec
    typedef enum logic [1:0] {
        FWD_REGFILE = 2'd0,
        FWD_REEXE   = 2'd1,
        FWD_COMMIT  = 2'd2
    } fwdSel_t;

endpackage

// File: hdl/execStage.sv
////////////////////
// execute stage
// holds the issued op, picks forwarded operands, runs the alu
// and flags overflow or trap
////////////////////
`timescale 1ns/1ps
module execStage
    import isaPkg::*, pipePkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 flush_i,
    // handshake with issue side
    input  logic                 valid_i,
    input  issueOp_t             op_i,
    output logic                 allowin_o,
    input  logic                 nextAllowin_i,
    // exception interlock from later stages
    input  logic                 riskIn_i,
    input  fwdPort_t             fwdReexe_i,
    input  fwdPort_t             fwdCommit_i,
    // register file read
    output logic [gprNum-1:0]    rdNumA_o,
    output logic [gprNum-1:0]    rdNumB_o,
    input  logic [wordWidth-1:0] rdDataA_i,
    input  logic [wordWidth-1:0] rdDataB_i,
    output logic                 valid_o,
    output stageData_t           data_o
);

    logic                 hasData;
    issueOp_t             opReg;
    logic                 stageFree;
    logic                 loadNew;
    logic                 ownRisk;
    fwdSel_t              selA;
    fwdSel_t              selB;
    logic [wordWidth-1:0] srcDataA;
    logic [wordWidth-1:0] srcDataB;
    logic [wordWidth-1:0] immExt;
    logic [wordWidth-1:0] opA;
    logic [wordWidth-1:0] opB;
    logic [wordWidth-1:0] sum;
    logic [wordWidth-1:0] aluRes;
    logic                 overflow;
    logic                 isTrap;

    // reexe wins over commit, commit over the register file
    function automatic fwdSel_t pickSource(input logic [gprNum-1:0] num,
                                           input fwdPort_t reexe,
                                           input fwdPort_t commit);
        fwdSel_t sel;
        sel = FWD_REGFILE;
        if (num != '0 && commit.valid && commit.writeNum == num) begin
            sel = FWD_COMMIT;
        end
        if (num != '0 && reexe.valid && reexe.writeNum == num) begin
            sel = FWD_REEXE;
        end
        return sel;
    endfunction

    function automatic logic [wordWidth-1:0] pickData(input fwdSel_t sel,
                                                      input fwdPort_t reexe,
                                                      input fwdPort_t commit,
                                                      input logic [wordWidth-1:0] regData);
        logic [wordWidth-1:0] value;
        case (sel)
            FWD_REEXE:  value = reexe.data;
            FWD_COMMIT: value = commit.data;
            default:    value = regData;
        endcase
        return value;
    endfunction

    ////////////////////
    // stage register and interlock
    ////////////////////
    // stage can move when empty or downstream takes its op
    assign stageFree = !hasData || nextAllowin_i;
    // no new op while an excepting op is anywhere in flight
    assign ownRisk   = hasData && data_o.hasException;
    assign allowin_o = stageFree && !riskIn_i && !ownRisk;
    assign loadNew   = allowin_o && valid_i;
    assign valid_o   = hasData;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            hasData <= 1'b0;
        end else if (stageFree) begin
            // empties if nothing new comes in
            hasData <= loadNew;
        end
    end

    always_ff @(posedge clk) begin
        if (loadNew) begin
            opReg <= op_i;
        end
    end

    ////////////////////
    // operand read
    ////////////////////
    assign rdNumA_o = opReg.srcA;
    assign rdNumB_o = opReg.srcB;
    assign selA     = pickSource(opReg.srcA, fwdReexe_i, fwdCommit_i);
    assign selB     = pickSource(opReg.srcB, fwdReexe_i, fwdCommit_i);
    assign srcDataA = pickData(selA, fwdReexe_i, fwdCommit_i, rdDataA_i);
    assign srcDataB = pickData(selB, fwdReexe_i, fwdCommit_i, rdDataB_i);

    // sign extended immediate replaces operand b
    assign immExt = {{(wordWidth-immWidth){opReg.imm[immWidth-1]}}, opReg.imm};
    assign opA    = srcDataA;
    assign opB    = opReg.useImm ? immExt : srcDataB;

    ////////////////////
    // alu
    ////////////////////
    assign sum = opA + opB;

    always_comb begin
        case (opReg.aluOp)
            ALU_SUB: aluRes = opA - opB;
            ALU_AND: aluRes = opA & opB;
            ALU_OR:  aluRes = opA | opB;
            ALU_XOR: aluRes = opA ^ opB;
            // shift amount from low 5 bits
            ALU_SLL: aluRes = opA << opB[4:0];
            ALU_LUI: aluRes = {opReg.imm, {(wordWidth-immWidth){1'b0}}};
            // add and addo share the adder
            default: aluRes = sum;
        endcase
    end

    // same input signs, different result sign
    assign overflow = (opReg.aluOp == ALU_ADDO) &&
                      (opA[wordWidth-1] == opB[wordWidth-1]) &&
                      (sum[wordWidth-1] != opA[wordWidth-1]);
    assign isTrap   = (opReg.kind == KIND_TRAP);

    // outgoing payload straight from the stage register
    always_comb begin
        data_o.writeNum     = opReg.dest;
        data_o.result       = aluRes;
        data_o.vaddr        = opReg.vaddr;
        data_o.hasException = isTrap || overflow;
        if (isTrap) begin
            data_o.excCode = EXC_TRAP;
        end else if (overflow) begin
            data_o.excCode = EXC_OVERFLOW;
        end else begin
            data_o.excCode = EXC_NONE;
        end
    end

endmodule

// File: reexe/reexeStage.sv
////////////////////
// delayed execute stage
// holds the alu result one more cycle, forwards it to exec
// and carries exception info toward commit
////////////////////
`timescale 1ns/1ps
module reexeStage
    import pipePkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  logic       flush_i,
    // from exec
    input  logic       valid_i,
    input  stageData_t data_i,
    output logic       allowin_o,
    // commit allowin
    input  logic       nextAllowin_i,
    // exception interlock
    input  logic       riskCommit_i,
    output logic       riskOut_o,
    // result bypass to exec
    output fwdPort_t   fwd_o,
    // to commit
    output logic       valid_o,
    output stageData_t data_o
);

    logic       hasData;
    stageData_t dataReg;
    logic       loadNew;

    ////////////////////
    // interlock
    ////////////////////
    assign allowin_o = !hasData || nextAllowin_i;
    assign loadNew   = allowin_o && valid_i;
    assign valid_o   = hasData;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            hasData <= 1'b0;
        end else if (allowin_o) begin
            // loads a new op or drains to empty
            hasData <= valid_i;
        end
    end

    // result and exception payload
    always_ff @(posedge clk) begin
        if (loadNew) begin
            dataReg <= data_i;
        end
    end

    assign data_o = dataReg;

    ////////////////////
    // forwarding and risk
    ////////////////////
    // excepting ops never write, so never forward them
    assign fwd_o.valid    = hasData && !dataReg.hasException;
    assign fwd_o.writeNum = dataReg.writeNum;
    assign fwd_o.data     = dataReg.result;

    // own exception or one already waiting in commit
    assign riskOut_o = (hasData && dataReg.hasException) || riskCommit_i;

endmodule

// File: hdl/regFile.sv
////////////////////
// general purpose register file
// 32 x 32, two async read ports, one write port, r0 reads zero
////////////////////
`timescale 1ns/1ps
module regFile
    import isaPkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    // read ports
    input  logic [gprNum-1:0]    rdNumA_i,
    input  logic [gprNum-1:0]    rdNumB_i,
    output logic [wordWidth-1:0] rdDataA_o,
    output logic [wordWidth-1:0] rdDataB_o,
    // write port where number 0 means no write
    input  logic [gprNum-1:0]    wrNum_i,
    input  logic [wordWidth-1:0] wrData_i
);

    logic [wordWidth-1:0] regs [gprCount];

    // all registers come up zero
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < gprCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrNum_i != '0) begin
            regs[wrNum_i] <= wrData_i;
        end
    end

    // reads show the old value in the write cycle
    // commit forwarding supplies the new one
    assign rdDataA_o = (rdNumA_i == '0) ? '0 : regs[rdNumA_i];
    assign rdDataB_o = (rdNumB_i == '0) ? '0 : regs[rdNumB_i];

endmodule

// File: hdl/commitStage.sv
////////////////////
// commit stage
// writes the register file, reports retired ops
// and raises the flush for an excepting op
////////////////////
`timescale 1ns/1ps
module commitStage
    import isaPkg::*, pipePkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    // from reexe
    input  logic                 valid_i,
    input  stageData_t           data_i,
    output logic                 allowin_o,
    // consumer allowin
    input  logic                 commitReady_i,
    output fwdPort_t             fwd_o,
    output logic                 risk_o,
    output logic                 flush_o,
    // register file write
    output logic [gprNum-1:0]    wrNum_o,
    output logic [wordWidth-1:0] wrData_o,
    // reports
    output logic                 commitValid_o,
    output commitInfo_t          commitInfo_o,
    output logic                 excValid_o,
    output excInfo_t             excInfo_o
);

    logic       hasData;
    stageData_t dataReg;
    logic       isNormal;
    logic       isExcept;
    logic       retire;
    logic       loadNew;

    ////////////////////
    // stage register
    ////////////////////
    assign allowin_o = !hasData || commitReady_i;
    assign isNormal  = hasData && !dataReg.hasException;
    assign isExcept  = hasData && dataReg.hasException;
    assign retire    = isNormal && commitReady_i;
    // excepting head leaves on the flush edge
    assign flush_o   = isExcept && commitReady_i;
    // nothing is taken in on the flush edge
    assign loadNew   = allowin_o && valid_i && !flush_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hasData <= 1'b0;
        end else if (allowin_o) begin
            hasData <= loadNew;
        end
    end

    always_ff @(posedge clk) begin
        if (loadNew) begin
            dataReg <= data_i;
        end
    end

    ////////////////////
    // write, bypass, risk
    ////////////////////
    // write lands on the retire edge
    assign wrNum_o  = retire ? dataReg.writeNum : '0;
    assign wrData_o = dataReg.result;

    assign fwd_o.valid    = isNormal;
    assign fwd_o.writeNum = dataReg.writeNum;
    assign fwd_o.data     = dataReg.result;

    // holds reexe and exec closed until the flush
    assign risk_o = isExcept;

    // commit report counts only with commitReady_i
    assign commitValid_o         = isNormal;
    assign commitInfo_o.writeNum = dataReg.writeNum;
    assign commitInfo_o.data     = dataReg.result;
    assign commitInfo_o.vaddr    = dataReg.vaddr;

    // exception report lasts one cycle with the flush
    assign excValid_o        = flush_o;
    assign excInfo_o.excCode = dataReg.excCode;
    assign excInfo_o.epc     = dataReg.vaddr;

endmodule

// File: hdl/backEnd.sv
////////////////////
// integer back end top
// exec, reexe and commit stages around the register file
////////////////////
`timescale 1ns/1ps
module backEnd
    import isaPkg::*, pipePkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    // issue handshake
    input  logic        issueValid_i,
    input  issueOp_t    issueOp_i,
    output logic        issueReady_o,
    // commit and exception reports
    input  logic        commitReady_i,
    output logic        commitValid_o,
    output commitInfo_t commitInfo_o,
    output logic        excValid_o,
    output excInfo_t    excInfo_o
);

    // exec to reexe
    logic                 exValid;
    stageData_t           exData;
    // reexe to commit
    logic                 reValid;
    stageData_t           reData;
    logic                 reAllowin;
    logic                 cmAllowin;
    // interlock and flush
    logic                 riskCommit;
    logic                 riskReexe;
    logic                 flush;
    // bypass
    fwdPort_t             fwdReexe;
    fwdPort_t             fwdCommit;
    // register file ports
    logic [gprNum-1:0]    rdNumA;
    logic [gprNum-1:0]    rdNumB;
    logic [wordWidth-1:0] rdDataA;
    logic [wordWidth-1:0] rdDataB;
    logic [gprNum-1:0]    wrNum;
    logic [wordWidth-1:0] wrData;

    execStage uExec (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (flush),
        .valid_i       (issueValid_i),
        .op_i          (issueOp_i),
        .allowin_o     (issueReady_o),
        .nextAllowin_i (reAllowin),
        .riskIn_i      (riskReexe),
        .fwdReexe_i    (fwdReexe),
        .fwdCommit_i   (fwdCommit),
        .rdNumA_o      (rdNumA),
        .rdNumB_o      (rdNumB),
        .rdDataA_i     (rdDataA),
        .rdDataB_i     (rdDataB),
        .valid_o       (exValid),
        .data_o        (exData)
    );

    reexeStage uReexe (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (flush),
        .valid_i       (exValid),
        .data_i        (exData),
        .allowin_o     (reAllowin),
        .nextAllowin_i (cmAllowin),
        .riskCommit_i  (riskCommit),
        .riskOut_o     (riskReexe),
        .fwd_o         (fwdReexe),
        .valid_o       (reValid),
        .data_o        (reData)
    );

    regFile uRegFile (
        .clk       (clk),
        .rst_i     (rst_i),
        .rdNumA_i  (rdNumA),
        .rdNumB_i  (rdNumB),
        .rdDataA_o (rdDataA),
        .rdDataB_o (rdDataB),
        .wrNum_i   (wrNum),
        .wrData_i  (wrData)
    );

    commitStage uCommit (
        .clk           (clk),
        .rst_i         (rst_i),
        .valid_i       (reValid),
        .data_i        (reData),
        .allowin_o     (cmAllowin),
        .commitReady_i (commitReady_i),
        .fwd_o         (fwdCommit),
        .risk_o        (riskCommit),
        .flush_o       (flush),
        .wrNum_o       (wrNum),
        .wrData_o      (wrData),
        .commitValid_o (commitValid_o),
        .commitInfo_o  (commitInfo_o),
        .excValid_o    (excValid_o),
        .excInfo_o     (excInfo_o)
    );

endmodule

// File: verif/tbClock.sv
////////////////////
// testbench clock source
// free running, 8 ns period
////////////////////
`timescale 1ns/1ps
module tbClock (
    output logic clk_o
);

    // half of the 8 ns period
    localparam time halfPeriod = 4ns;

    initial clk_o = 1'b0;

    always #(halfPeriod) clk_o = ~clk_o;

endmodule

// File: verif/backEnd_properties.sv
////////////////////
// back end interface rules
// interlock during a flush, exception pulse width,
// commit and exception exclusive
////////////////////
`timescale 1ns/1ps
module backEnd_properties (
    input logic clk,
    input logic rst_i,
    input logic issueReady_i,
    input logic commitValid_i,
    input logic excValid_i
);

    // issue stays closed while the excepting op leaves
    property noIssueOnExc;
        @(posedge clk) disable iff (rst_i)
            excValid_i |-> !issueReady_i;
    endproperty

    // one cycle pulse per exception
    property excSinglePulse;
        @(posedge clk) disable iff (rst_i)
            excValid_i |=> !excValid_i;
    endproperty

    property commitExcExclusive;
        @(posedge clk) disable iff (rst_i)
            !(commitValid_i && excValid_i);
    endproperty

    assert property (noIssueOnExc)
        else $error("issueReady_o high while excValid_o is high");
    assert property (excSinglePulse)
        else $error("excValid_o held longer than one cycle");
    assert property (commitExcExclusive)
        else $error("commitValid_o and excValid_o high together");

endmodule

// attach to every back end instance
bind backEnd backEnd_properties uProps (
    .clk           (clk),
    .rst_i         (rst_i),
    .issueReady_i  (issueReady_o),
    .commitValid_i (commitValid_o),
    .excValid_i    (excValid_o)
);

// File: verif/backEndTb.sv
////////////////////
// back end testbench
// random ops from an lcg, in-order queue model with its own
// register file, commit and exception checks
////////////////////
`timescale 1ns/1ps
module backEndTb
    import isaPkg::*, pipePkg::*;
();

    localparam int numOps     = 400;
    localparam int issueLimit = 20000;
    localparam int drainLimit = 1000;
    localparam logic [31:0] seedValue = 32'h43de_e0ba;

    logic        clk;
    logic        rst;
    logic        issueValid;
    issueOp_t    issueOp;
    logic        issueReady;
    logic        commitReady;
    logic        commitValid;
    commitInfo_t commitInfo;
    logic        excValid;
    excInfo_t    excInfo;

    // model state
    logic [31:0] rngState;
    logic [31:0] modelRegs [32];
    issueOp_t    pendingQ [$];
    logic [31:0] nextVaddr;
    logic        opTaken;
    int          acceptCount;
    int          commitCount;
    int          excCount;
    int          dropCount;
    int          cycleCount;

    tbClock uClock (
        .clk_o (clk)
    );

    backEnd UUT (
        .clk           (clk),
        .rst_i         (rst),
        .issueValid_i  (issueValid),
        .issueOp_i     (issueOp),
        .issueReady_o  (issueReady),
        .commitReady_i (commitReady),
        .commitValid_o (commitValid),
        .commitInfo_o  (commitInfo),
        .excValid_o    (excValid),
        .excInfo_o     (excInfo)
    );

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // regs 0..7 only to keep hazards dense
    function automatic issueOp_t makeOp(input logic [31:0] vaddr);
        issueOp_t    op;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        r1 = nextRand();
        r2 = nextRand();
        r3 = nextRand();
        op.dest   = {2'b00, r1[31:29]};
        op.srcA   = {2'b00, r1[28:26]};
        op.srcB   = {2'b00, r1[25:23]};
        op.useImm = r1[22];
        op.aluOp  = aluOp_t'(r1[21:19]);
        op.imm    = r2[31:16];
        // about 3 in 100 are traps
        op.kind   = (((r3 >> 8) % 32'd100) < 32'd3) ? KIND_TRAP : KIND_NORMAL;
        op.vaddr  = vaddr;
        return op;
    endfunction

    ////////////////////
    // reference model
    ////////////////////
    function automatic logic [31:0] readModel(input logic [4:0] num);
        return (num == 5'd0) ? 32'd0 : modelRegs[num];
    endfunction

    function automatic logic [31:0] operandB(input issueOp_t op);
        if (op.useImm) begin
            return {{16{op.imm[15]}}, op.imm};
        end
        return readModel(op.srcB);
    endfunction

    function automatic logic [31:0] modelResult(input issueOp_t op);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = readModel(op.srcA);
        b = operandB(op);
        case (op.aluOp)
            ALU_SUB: res = a - b;
            ALU_AND: res = a & b;
            ALU_OR:  res = a | b;
            ALU_XOR: res = a ^ b;
            ALU_SLL: res = a << b[4:0];
            ALU_LUI: res = {op.imm, 16'h0000};
            default: res = a + b;
        endcase
        return res;
    endfunction

    // trap first, then signed overflow of addo
    function automatic logic [4:0] modelExcCode(input issueOp_t op);
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] wide;
        logic [4:0]  code;
        a    = readModel(op.srcA);
        b    = operandB(op);
        wide = {a[31], a} + {b[31], b};
        code = EXC_NONE;
        if (op.kind == KIND_TRAP) begin
            code = EXC_TRAP;
        end else if (op.aluOp == ALU_ADDO && wide[32] != wide[31]) begin
            code = EXC_OVERFLOW;
        end
        return code;
    endfunction

    ////////////////////
    // checking
    ////////////////////
    task automatic abortRun();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkEqual(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("timeout while %s, cycle limit reached", what);
        abortRun();
    endtask

    // inputs move 1 ns after the edge
    task automatic driveInputs();
        logic [31:0] r;
        if (opTaken) begin
            nextVaddr = nextVaddr + 32'd4;
            issueOp   = makeOp(nextVaddr);
            opTaken   = 1'b0;
        end
        r = nextRand();
        issueValid  = (acceptCount < numOps) && (r[31:30] != 2'b00);
        r = nextRand();
        commitReady = (r[31:30] != 2'b00);
    endtask

    // sampled mid cycle to act on what the next edge does
    task automatic observeCycle();
        issueOp_t head;
        if (commitValid && commitReady) begin
            checkEqual("model op present at commit", 32'(pendingQ.size() != 0), 32'd1);
            head = pendingQ.pop_front();
            checkEqual("exception code of committed op", 32'(modelExcCode(head)), 32'd0);
            checkEqual("commit writeNum", 32'(commitInfo.writeNum), 32'(head.dest));
            checkEqual("commit data", commitInfo.data, modelResult(head));
            checkEqual("commit vaddr", commitInfo.vaddr, head.vaddr);
            if (head.dest != 5'd0) begin
                modelRegs[head.dest] = modelResult(head);
            end
            commitCount++;
        end
        if (excValid) begin
            checkEqual("model op present at exception", 32'(pendingQ.size() != 0), 32'd1);
            head = pendingQ.pop_front();
            checkEqual("exception code", 32'(excInfo.excCode), 32'(modelExcCode(head)));
            checkEqual("exception epc", excInfo.epc, head.vaddr);
            excCount++;
            // younger ops die with the flush
            dropCount += pendingQ.size();
            pendingQ.delete();
        end
        if (issueValid && issueReady) begin
            pendingQ.push_back(issueOp);
            acceptCount++;
            opTaken = 1'b1;
        end
    endtask

    task automatic runCycle();
        @(posedge clk);
        #1;
        driveInputs();
        #5;
        observeCycle();
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        rngState    = seedValue;
        rst         = 1'b1;
        issueValid  = 1'b0;
        issueOp     = '0;
        commitReady = 1'b0;
        opTaken     = 1'b0;
        acceptCount = 0;
        commitCount = 0;
        excCount    = 0;
        dropCount   = 0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'd0;
        end
        nextVaddr = 32'h0000_1000;
        issueOp   = makeOp(nextVaddr);

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        #5;
        checkEqual("commitValid after reset", 32'(commitValid), 32'd0);
        checkEqual("excValid after reset", 32'(excValid), 32'd0);
        checkEqual("issueReady after reset", 32'(issueReady), 32'd1);

        cycleCount = 0;
        while (acceptCount < numOps) begin
            if (cycleCount == issueLimit) begin
                reportTimeout("issuing all operations");
            end
            runCycle();
            cycleCount++;
        end

        // no more issue while the pipe empties
        cycleCount = 0;
        while (pendingQ.size() != 0) begin
            if (cycleCount == drainLimit) begin
                reportTimeout("draining the pipeline");
            end
            runCycle();
            cycleCount++;
        end

        // stray commits after the drain would show here
        repeat (8) runCycle();

        $display("accepted %0d, committed %0d, exceptions %0d, dropped %0d",
                 acceptCount, commitCount, excCount, dropCount);
        // every op is accounted for so the pipe must sit idle and open
        checkEqual("commitValid after drain", 32'(commitValid), 32'd0);
        checkEqual("excValid after drain", 32'(excValid), 32'd0);
        checkEqual("issueReady after drain", 32'(issueReady), 32'd1);
        checkEqual("exceptions were seen", 32'(excCount != 0), 32'd1);
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: sim.f
common/isaPkg.sv
common/pipePkg.sv
hdl/execStage.sv
reexe/reexeStage.sv
hdl/regFile.sv
hdl/commitStage.sv
hdl/backEnd.sv
verif/tbClock.sv
verif/backEnd_properties.sv
verif/backEndTb.sv

// File: run.sh
#!/bin/sh
# build and run the back end testbench with verilator
verilator --binary --timing --assert --top-module backEndTb -f sim.f \
    && { out="$(./obj_dir/VbackEndTb 2>&1)"; echo "$out"; } \
    && echo "$out" | grep -qF "All tests passed!" \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }
